//--- sig_params.svh
`ifndef SIG_PARAMS_SVH
`define SIG_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Input alignment buffer
//////////////////////////////////////////////////////////////////////

// Samples held between the conv output and the sigmoid core
`define SIG_FIFO_DEPTH 4

//////////////////////////////////////////////////////////////////////
// Lookup table
//////////////////////////////////////////////////////////////////////

// 32 entries, one per 0.25 step of |x| over 0 to 8
`define SIG_ADDR_W 5

// Biased exponent from which |x| >= 8.0 (2^3)
`define SIG_SAT_EXP 130

`endif

//--- sig_pkg.sv
`default_nettype none

package sig_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sample format
	//////////////////////////////////////////////////////////////////////

	// IEEE single precision word
	typedef struct packed {
		logic        sign;
		logic [7:0]  exponent;
		logic [22:0] mantissa;
	} fp32_t;

	//////////////////////////////////////////////////////////////////////
	// Classifier result
	//////////////////////////////////////////////////////////////////////

	// How the combiner forms the output
	typedef enum logic [1:0] {
		CLS_TABLE  = 2'd0,
		CLS_SAT_HI = 2'd1,
		CLS_SAT_LO = 2'd2
	} sig_class_e;

	// Sign kept apart for the reflection step
	typedef struct packed {
		logic       sign;
		sig_class_e cls;
	} class_res_t;

	//////////////////////////////////////////////////////////////////////
	// Core control
	//////////////////////////////////////////////////////////////////////

	// One pass per sample, then wait for req to fall
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_FETCH   = 2'd1,
		ST_COMBINE = 2'd2,
		ST_ACK     = 2'd3
	} core_state_e;

endpackage

`default_nettype wire

//--- sig_input_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "sig_params.svh"

module sig_input_buffer (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  in_valid,
	input  wire sig_pkg::fp32_t  in_fp,
	output logic                 in_ready,
	output logic                 req,
	output sig_pkg::fp32_t       req_data,
	input  wire                  ack
);

	localparam int DEPTH = `SIG_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	sig_pkg::fp32_t   mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign in_ready = (count != (PTR_W+1)'(DEPTH));
	assign push     = in_valid && in_ready;
	// Entry leaves only once the core has acknowledged it
	assign pop      = req && ack;
	assign req_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_fp;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pointers, fill level and request
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			req    <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Four-phase: drop on ack, rise again only after ack is low
			if (pop) begin
				req <= 1'b0;
			end else if (!req && !ack && (count != '0)) begin
				req <= 1'b1;
			end
		end
	end

	// Core samples req_data at any point of the request
	a_req_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(req && $past(req)) |-> $stable(req_data))
		else $error("req_data changed while req held");

	a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= (PTR_W+1)'(DEPTH))
		else $error("buffer count above depth");

endmodule

`default_nettype wire

//--- sig_classify.sv
`timescale 1ns/1ps
`default_nettype none
`include "sig_params.svh"

module sig_classify (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  load,
	input  wire sig_pkg::fp32_t  sample,
	output sig_pkg::class_res_t  cls
);

	localparam logic [7:0] SAT_EXP = 8'(`SIG_SAT_EXP);

	sig_pkg::sig_class_e cls_c;
	logic                is_sat;

	//////////////////////////////////////////////////////////////////////
	// Class decode
	//////////////////////////////////////////////////////////////////////

	// |x| >= 8, inf and NaN all sit at or above this exponent
	assign is_sat = (sample.exponent >= SAT_EXP);

	always_comb begin
		if (!is_sat) begin
			cls_c = sig_pkg::CLS_TABLE;
		end else if (sample.sign) begin
			// sigmoid(-inf) side
			cls_c = sig_pkg::CLS_SAT_LO;
		end else begin
			cls_c = sig_pkg::CLS_SAT_HI;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Result register
	//////////////////////////////////////////////////////////////////////

	// Held until the next load so the combiner can fire later
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cls.sign <= 1'b0;
			cls.cls  <= sig_pkg::CLS_TABLE;
		end else if (load) begin
			cls.sign <= sample.sign;
			cls.cls  <= cls_c;
		end
	end

endmodule

`default_nettype wire

//--- sig_table_lookup.sv
`timescale 1ns/1ps
`default_nettype none
`include "sig_params.svh"

module sig_table_lookup (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    load,
	input  wire sig_pkg::fp32_t    sample,
	output logic [`SIG_ADDR_W-1:0] addr,
	output logic                   read_en,
	input  wire [31:0]             rom_val,
	output sig_pkg::fp32_t         value
);

	// Smallest exponent with |x| >= 0.25 and so address 1 or above
	localparam logic [7:0] EXP_QUARTER = 8'd125;
	// 125 + 23 aligns the implicit one to the address LSB
	localparam logic [7:0] EXP_SHIFT_BASE = 8'd148;

	logic [23:0]            mant_full;
	logic [7:0]             shift;
	logic [23:0]            mant_shifted;
	logic [`SIG_ADDR_W-1:0] addr_c;

	//////////////////////////////////////////////////////////////////////
	// Address as floor(|x| * 4)
	//////////////////////////////////////////////////////////////////////

	assign mant_full    = {1'b1, sample.mantissa};
	assign shift        = EXP_SHIFT_BASE - sample.exponent;
	assign mant_shifted = mant_full >> shift;

	always_comb begin
		// Zero, denormals and |x| < 0.25 land in entry 0
		if (sample.exponent < EXP_QUARTER) begin
			addr_c = '0;
		end else begin
			// Saturating inputs read some entry, unused downstream
			addr_c = mant_shifted[`SIG_ADDR_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			addr <= addr_c;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Table read with one cycle latency
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			read_en <= 1'b0;
		end else begin
			read_en <= load;
		end
	end

	// Word is consumed by the combiner in its return cycle
	assign value = sig_pkg::fp32_t'(rom_val);

	a_read_en_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		read_en |=> !read_en)
		else $error("read_en held for two cycles");

endmodule

`default_nettype wire

//--- sig_combine.sv
`timescale 1ns/1ps
`default_nettype none

module sig_combine (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       fire,
	input  wire sig_pkg::class_res_t  cls,
	input  wire sig_pkg::fp32_t       value,
	output sig_pkg::fp32_t            out_fp,
	output logic                      top_overflow,
	output logic                      top_underflow,
	output logic                      done
);

	localparam logic [31:0] FP_ONE  = 32'h3F80_0000;
	localparam logic [31:0] FP_ZERO = 32'h0000_0000;

	// Position of the first set bit from the top, 24 for zero
	function automatic logic [4:0] count_lz(input logic [23:0] v);
		logic [4:0] n;
		n = 5'd24;
		for (int i = 0; i < 24; i++) begin
			if (v[i]) begin
				n = 5'(23 - i);
			end
		end
		return n;
	endfunction

	logic [23:0]    value_fx;
	logic [23:0]    diff;
	logic [4:0]     lz;
	logic [23:0]    diff_norm;
	sig_pkg::fp32_t reflected;
	sig_pkg::fp32_t table_res;

	//////////////////////////////////////////////////////////////////////
	// Reflection 1 - value, value in [0.5, 1)
	//////////////////////////////////////////////////////////////////////

	// Exponent 126 means value = value_fx * 2^-24
	assign value_fx  = {1'b1, value.mantissa};
	assign diff      = 24'(25'h100_0000 - {1'b0, value_fx});
	assign lz        = count_lz(diff);
	assign diff_norm = diff << lz;

	always_comb begin
		reflected.sign     = 1'b0;
		reflected.exponent = 8'd126 - {3'b000, lz};
		reflected.mantissa = diff_norm[22:0];
		if (diff == '0) begin
			reflected = FP_ZERO;
		end
	end

	assign table_res = cls.sign ? reflected : value;

	//////////////////////////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (fire) begin
			case (cls.cls)
				sig_pkg::CLS_SAT_HI: out_fp <= FP_ONE;
				sig_pkg::CLS_SAT_LO: out_fp <= FP_ZERO;
				default:             out_fp <= table_res;
			endcase
		end
	end

	// Flags are pulses aligned with done
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done          <= 1'b0;
			top_overflow  <= 1'b0;
			top_underflow <= 1'b0;
		end else begin
			done          <= fire;
			top_overflow  <= fire && (cls.cls == sig_pkg::CLS_SAT_HI);
			top_underflow <= fire && (cls.cls == sig_pkg::CLS_SAT_LO);
		end
	end

	a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(top_overflow && top_underflow))
		else $error("overflow and underflow both set");

endmodule

`default_nettype wire

//--- sig_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "sig_params.svh"

module sig_core (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    req,
	input  wire sig_pkg::fp32_t    req_data,
	output logic                   ack,
	output logic [`SIG_ADDR_W-1:0] addr,
	output logic                   read_en,
	input  wire [31:0]             rom_val,
	output sig_pkg::fp32_t         out_fp,
	output logic                   top_overflow,
	output logic                   top_underflow,
	output logic                   done
);

	sig_pkg::core_state_e state;
	sig_pkg::core_state_e state_nxt;
	logic                 load;
	logic                 fire;
	sig_pkg::class_res_t  cls;
	sig_pkg::fp32_t       value;

	//////////////////////////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			sig_pkg::ST_IDLE:    if (req) state_nxt = sig_pkg::ST_FETCH;
			sig_pkg::ST_FETCH:   state_nxt = sig_pkg::ST_COMBINE;
			sig_pkg::ST_COMBINE: state_nxt = sig_pkg::ST_ACK;
			// Hold ack until the buffer drops req
			sig_pkg::ST_ACK:     if (!req) state_nxt = sig_pkg::ST_IDLE;
			default:             state_nxt = sig_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= sig_pkg::ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign load = (state == sig_pkg::ST_IDLE) && req;
	assign fire = (state == sig_pkg::ST_COMBINE);
	assign ack  = (state == sig_pkg::ST_ACK);

	// Classifier and lookup run side by side on the same sample
	sig_classify u_classify (
		.clk    (clk),
		.rst_n  (rst_n),
		.load   (load),
		.sample (req_data),
		.cls    (cls)
	);

	sig_table_lookup u_lookup (
		.clk     (clk),
		.rst_n   (rst_n),
		.load    (load),
		.sample  (req_data),
		.addr    (addr),
		.read_en (read_en),
		.rom_val (rom_val),
		.value   (value)
	);

	sig_combine u_combine (
		.clk           (clk),
		.rst_n         (rst_n),
		.fire          (fire),
		.cls           (cls),
		.value         (value),
		.out_fp        (out_fp),
		.top_overflow  (top_overflow),
		.top_underflow (top_underflow),
		.done          (done)
	);

	// Table read at cycle 1, result at cycle 3
	a_load_to_done: assert property (@(posedge clk) disable iff (!rst_n)
		load |=> read_en ##2 done)
		else $error("done not two cycles after read_en");

	a_ack_with_done: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> done)
		else $error("ack rose without done");

endmodule

`default_nettype wire

//--- sigmoid_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "sig_params.svh"

module sigmoid_top (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    in_valid,
	input  wire sig_pkg::fp32_t    in_fp,
	output logic                   in_ready,
	input  wire [31:0]             rom_val,
	output logic [`SIG_ADDR_W-1:0] addr,
	output logic                   read_en,
	output sig_pkg::fp32_t         out_fp,
	output logic                   top_overflow,
	output logic                   top_underflow,
	output logic                   done
);

	// Four-phase link between buffer and core
	wire                 req;
	wire                 ack;
	wire sig_pkg::fp32_t req_data;

	sig_input_buffer u_buffer (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_fp    (in_fp),
		.in_ready (in_ready),
		.req      (req),
		.req_data (req_data),
		.ack      (ack)
	);

	sig_core u_core (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req),
		.req_data      (req_data),
		.ack           (ack),
		.addr          (addr),
		.read_en       (read_en),
		.rom_val       (rom_val),
		.out_fp        (out_fp),
		.top_overflow  (top_overflow),
		.top_underflow (top_underflow),
		.done          (done)
	);

endmodule

`default_nettype wire

//--- tb_sigmoid_rom.sv
`timescale 1ns/1ps
`default_nettype none
`include "sig_params.svh"

module tb_sigmoid_rom (
	input  wire                    clk,
	input  wire                    read_en,
	input  wire [`SIG_ADDR_W-1:0]  addr,
	output logic [31:0]            rom_val
);

	localparam int ENTRIES = 1 << `SIG_ADDR_W;

	logic [31:0] mem [ENTRIES];

	// Double to single, round to nearest even, normal range only
	function automatic logic [31:0] real_to_single(input real r);
		logic [63:0] d;
		logic [24:0] m;
		logic [7:0]  ex;
		d = $realtobits(r);
		m = {1'b1, d[51:29]} + 25'(d[28] && ((d[27:0] != '0) || d[29]));
		// Mantissa carry out bumps the exponent
		ex = 8'(d[62:52] - 11'd896 + 11'(m[24]));
		return {d[63], ex, m[22:0]};
	endfunction

	// Entry k is sigmoid at the middle of its 0.25 wide bin
	initial begin
		for (int k = 0; k < ENTRIES; k++) begin
			mem[k] = real_to_single(1.0 / (1.0 + $exp(-(k + 0.5) / 4.0)));
		end
		rom_val = '0;
	end

	always @(posedge clk) begin
		if (read_en) begin
			rom_val <= mem[addr];
		end
	end

endmodule

`default_nettype wire

//--- tb_sigmoid_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "sig_params.svh"

module tb_sigmoid_top;

	localparam int NUM_DIRECTED = 20;
	localparam int NUM_BURST    = 6;
	localparam int NUM_RANDOM   = 24;
	localparam int MAX_CYCLES   = 40 * (NUM_DIRECTED + NUM_BURST + NUM_RANDOM) + 200;

	// One accepted sample and what the core must return for it
	typedef struct packed {
		logic [31:0] sample;
		logic [31:0] fp;
		logic        ovf;
		logic        udf;
	} expect_t;

	logic                   clk;
	logic                   rst_n;
	logic                   in_valid;
	sig_pkg::fp32_t         in_fp;
	wire                    in_ready;
	wire [31:0]             rom_val;
	wire [`SIG_ADDR_W-1:0]  addr;
	wire                    read_en;
	wire sig_pkg::fp32_t    out_fp;
	wire                    top_overflow;
	wire                    top_underflow;
	wire                    done;

	expect_t     pending [$];
	expect_t     head;
	int          accepted;
	int          completed;
	int          read_pulses;
	int          cycles;
	int          value_errors;
	int          protocol_errors;
	integer      seed;
	logic        saw_full;
	logic [31:0] rnd;
	logic [7:0]  rnd_exp;

	always #50 clk = ~clk;

	sigmoid_top dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_fp         (in_fp),
		.in_ready      (in_ready),
		.rom_val       (rom_val),
		.addr          (addr),
		.read_en       (read_en),
		.out_fp        (out_fp),
		.top_overflow  (top_overflow),
		.top_underflow (top_underflow),
		.done          (done)
	);

	tb_sigmoid_rom u_rom (
		.clk     (clk),
		.read_en (read_en),
		.addr    (addr),
		.rom_val (rom_val)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Exponent 255 maps to a huge finite value, so inf and NaN land above 8
	function automatic real single_to_real(input logic [31:0] f);
		if (f[30:23] == 8'd0) begin
			return 0.0;
		end
		return $bitstoreal({f[31], 11'(f[30:23]) + 11'd896, f[22:0], 29'd0});
	endfunction

	function automatic logic [31:0] real_to_single(input real r);
		logic [63:0] d;
		logic [24:0] m;
		d = $realtobits(r);
		m = {1'b1, d[51:29]} + 25'(d[28] && ((d[27:0] != '0) || d[29]));
		return {d[63], 8'(d[62:52] - 11'd896 + 11'(m[24])), m[22:0]};
	endfunction

	function automatic expect_t expected_result(input logic [31:0] x);
		expect_t     e;
		real         mag;
		logic [31:0] entry;
		mag      = single_to_real({1'b0, x[30:0]});
		e.sample = x;
		e.ovf    = (mag >= 8.0) && !x[31];
		e.udf    = (mag >= 8.0) && x[31];
		if (mag >= 8.0) begin
			e.fp = x[31] ? 32'h0000_0000 : 32'h3F80_0000;
		end else begin
			entry = u_rom.mem[$rtoi($floor(mag * 4.0))];
			// 1 - entry is exact in single since entry is in [0.5, 1)
			e.fp  = x[31] ? real_to_single(1.0 - single_to_real(entry)) : entry;
		end
		return e;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus entered and left #1 after a rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic send_sample(input logic [31:0] x);
		logic taken;
		taken    = 1'b0;
		in_valid = 1'b1;
		in_fp    = x;
		while (!taken) begin
			taken = in_ready;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	// Presents a new word every cycle whether or not it is taken
	task automatic send_burst(input logic [NUM_BURST-1:0][31:0] vals);
		for (int i = 0; i < NUM_BURST; i++) begin
			in_valid = 1'b1;
			in_fp    = vals[i];
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic drain_results;
		while (completed != accepted) begin
			@(posedge clk);
			#1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (rst_n) begin
			// Buffer fill level is accepted minus finished
			a_ready_level: assert (in_ready == ((accepted - completed) < `SIG_FIFO_DEPTH))
				else begin
					protocol_errors++;
					$display("error at %0t: in_ready %b with %0d waiting", $time, in_ready,
						accepted - completed);
				end
			if (!in_ready) begin
				saw_full = 1'b1;
			end
			if (in_valid && in_ready) begin
				pending.push_back(expected_result(in_fp));
				accepted++;
			end
			if (read_en) begin
				read_pulses++;
			end
			if (done) begin
				a_done_owed: assert (pending.size() > 0)
					else begin
						value_errors++;
						$display("error at %0t: done with no sample outstanding", $time);
					end
				if (pending.size() > 0) begin
					head = pending.pop_front();
					a_result: assert (out_fp == head.fp && top_overflow == head.ovf &&
						top_underflow == head.udf)
						else begin
							value_errors++;
							$display("error at %0t: in %h gave %h ovf %b udf %b, expected %h ovf %b udf %b",
								$time, head.sample, out_fp, top_overflow, top_underflow,
								head.fp, head.ovf, head.udf);
						end
				end
				completed++;
			end
		end
	end

	a_done_after_read: assert property (@(posedge clk) disable iff (!rst_n)
		read_en |-> ##2 done)
		else begin
			protocol_errors++;
			$display("error at %0t: done missing two cycles after read_en", $time);
		end

	a_read_before_done: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(read_en, 2))
		else begin
			protocol_errors++;
			$display("error at %0t: done without read_en two cycles before", $time);
		end

	a_flags_in_done: assert property (@(posedge clk) disable iff (!rst_n)
		(top_overflow || top_underflow) |-> done)
		else begin
			protocol_errors++;
			$display("error at %0t: flag raised outside the done cycle", $time);
		end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run still busy after %0d cycles", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk             = 1'b0;
		rst_n           = 1'b0;
		in_valid        = 1'b0;
		in_fp           = '0;
		accepted        = 0;
		completed       = 0;
		read_pulses     = 0;
		cycles          = 0;
		value_errors    = 0;
		protocol_errors = 0;
		saw_full        = 1'b0;
		seed            = 2;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		a_reset_idle: assert (in_ready && !read_en && !done && !top_overflow &&
			!top_underflow && !dut.u_buffer.req && !dut.u_core.ack)
			else begin
				protocol_errors++;
				$display("error at %0t: outputs or handshake still active after reset", $time);
			end
		// Positive in range with the last one just below 8
		send_sample(32'h3DCC_CCCD);
		send_sample(32'h3E80_0000);
		send_sample(32'h3F80_0000);
		send_sample(32'h4026_6666);
		send_sample(32'h40FF_FFFF);
		send_sample(32'h0000_0000);
		// Negative in range with -0 and a denormal
		send_sample(32'hBDCC_CCCD);
		send_sample(32'h8000_0000);
		send_sample(32'h8000_0001);
		send_sample(32'hBF40_0000);
		send_sample(32'hC053_3333);
		send_sample(32'hC0FF_FFFF);
		// Saturation at 8, inf, NaN and large values
		send_sample(32'h4100_0000);
		send_sample(32'hC100_0000);
		send_sample(32'h7F80_0000);
		send_sample(32'hFF80_0000);
		send_sample(32'h7FC0_0000);
		send_sample(32'hFFC0_0000);
		send_sample(32'h42C8_0000);
		send_sample(32'hD015_02F9);
		drain_results();
		saw_full = 1'b0;
		// 0.3, 1.3 ... 5.3 each in a different table entry
		send_burst({32'h40A9_999A, 32'h4089_999A, 32'h4053_3333,
			32'h4013_3333, 32'h3FA6_6666, 32'h3E99_999A});
		drain_results();
		a_burst_throttled: assert (saw_full)
			else begin
				protocol_errors++;
				$display("in_ready never fell during the six-sample burst");
			end
		for (int i = 0; i < NUM_RANDOM; i++) begin
			rnd     = $random(seed);
			rnd_exp = 8'(8'd118 + (rnd[31:24] % 12));
			send_sample({rnd[23], rnd_exp, rnd[22:0]});
		end
		drain_results();
		a_one_read_each: assert (read_pulses == accepted && pending.size() == 0)
			else begin
				protocol_errors++;
				$display("Table was read %0d times for %0d accepted samples", read_pulses, accepted);
			end
		$display("Results %0d, value errors %0d, protocol errors %0d", completed,
			value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
sig_pkg.sv
sig_input_buffer.sv
sig_classify.sv
sig_table_lookup.sv
sig_combine.sv
sig_core.sv
sigmoid_top.sv
tb_sigmoid_rom.sv
tb_sigmoid_top.sv
